// File: verilog.f
if_pkg.sv
if_prefetcher.sv
if_compressed_decoder.sv
if_dummy_gen.sv
if_stage_checker.sv
if_stage.sv
tb_if_stage.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_if_stage
FILELIST  = verilog.f
BUILD_DIR = obj_dir
SIM       = $(BUILD_DIR)/V$(TOP)
PASS_MSG  = *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	@out=$$(./$(SIM) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

// File: tb_if_stage.sv
////////////////////
// Fetch stage testbench
// Random controls, memory model and a reference halfword stream model
////////////////////

`timescale 1ns/10ps

module tb_if_stage;

  localparam int          RUN_CYCLES     = 3000;
  // A third of the run as margin on top of reset and the stimulus loop
  localparam int          TIMEOUT_CYCLES = RUN_CYCLES + RUN_CYCLES / 3;
  localparam int          MIN_XFERS      = 500;
  localparam int          FIFO_DEPTH     = 4;
  localparam logic [15:0] LFSR_SEED      = 16'hACE1;
  localparam logic [31:0] SEED           = 32'd8806;

  logic                 clk;
  logic                 rst_n;
  logic                 pc_set_i;
  logic [31:0]          branch_addr_i;
  logic                 halt_i;
  logic                 kill_i;
  logic                 dummy_en_i;
  logic                 id_ready_i;
  logic                 instr_req_o;
  logic [31:0]          instr_addr_o;
  logic                 instr_rvalid_i;
  logic [31:0]          instr_rdata_i;
  logic                 if_valid_o;
  logic [31:0]          instr_o;
  logic [31:0]          pc_o;
  logic                 compressed_o;
  logic                 illegal_c_o;
  logic                 dummy_o;
  logic                 alert_o;
  if_pkg::alert_cause_e alert_cause_o;

  // Reference model state
  logic [31:0] lcg_state;
  logic [31:0] model_pc;
  logic [31:0] redirect_pc;
  logic        after_redirect;
  logic        last_xfer_dummy;
  // Bus and handshake history from the previous cycle
  logic        req_prev;
  logic [31:0] addr_prev;
  logic        kill_prev;
  logic        hold_prev;
  logic [31:0] held_instr;
  logic [31:0] held_pc;
  logic [2:0]  held_flags;
  logic        redirect;
  int          halt_left;
  int          xfer_count;
  int          dummy_count;
  int          cycle_count;

  if_stage #(
    .FIFO_DEPTH(FIFO_DEPTH),
    .LFSR_SEED (LFSR_SEED)
  ) dut0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .pc_set_i      (pc_set_i),
    .branch_addr_i (branch_addr_i),
    .halt_i        (halt_i),
    .kill_i        (kill_i),
    .dummy_en_i    (dummy_en_i),
    .id_ready_i    (id_ready_i),
    .instr_req_o   (instr_req_o),
    .instr_addr_o  (instr_addr_o),
    .instr_rvalid_i(instr_rvalid_i),
    .instr_rdata_i (instr_rdata_i),
    .if_valid_o    (if_valid_o),
    .instr_o       (instr_o),
    .pc_o          (pc_o),
    .compressed_o  (compressed_o),
    .illegal_c_o   (illegal_c_o),
    .dummy_o       (dummy_o),
    .alert_o       (alert_o),
    .alert_cause_o (alert_cause_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////
  // Error handling
  ////////////////////

  task automatic stop_failed();
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic fail_run(input string what);
    $display("ERROR %s", what);
    stop_failed();
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("MISMATCH %s expected 0x%08h actual 0x%08h", name, expected, actual);
      stop_failed();
    end
  endtask

  ////////////////////
  // Random source and memory contents
  ////////////////////

  // Plain LCG whose upper state bits are the better distributed ones
  function automatic logic [31:0] rand_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {16'h0000, lcg_state[30:15]};
  endfunction

  function automatic logic [31:0] mix32(input logic [31:0] x);
    logic [31:0] h;
    h = x ^ 32'h5bd1e995;
    h = h * 32'h9e3779b1;
    h = h ^ (h >> 15);
    h = h * 32'h85ebca6b;
    h = h ^ (h >> 13);
    return h;
  endfunction

  // Bends a random parcel towards the encodings the stage cares about
  function automatic logic [15:0] shape_half(input logic [15:0] r, input logic [1:0] kind);
    logic [15:0] p;
    p = r;
    case (kind)
      // Start of a 32-bit instruction
      2'd0: p[1:0] = 2'b11;
      2'd1: begin
        // C.ADDI or C.LI
        p[1:0]   = 2'b01;
        p[15:13] = {1'b0, r[13], 1'b0};
      end
      2'd2: begin
        // C.MV or C.ADD, or C.JR style when rs2 is zero
        p[1:0]   = 2'b10;
        p[15:13] = 3'b100;
      end
      default: p = r;
    endcase
    return p;
  endfunction

  // Every word is a fixed function of its word address
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [31:0] x;
    logic [31:0] y;
    x = mix32({2'b00, addr[31:2]});
    y = mix32(x);
    return {shape_half(x[31:16], y[3:2]), shape_half(x[15:0], y[1:0])};
  endfunction

  function automatic logic [15:0] mem_half(input logic [31:0] addr);
    logic [31:0] w;
    w = mem_word(addr);
    return addr[1] ? w[31:16] : w[15:0];
  endfunction

  ////////////////////
  // Reference model
  ////////////////////

  // RVC expansion of the supported subset with everything else flagged
  task automatic expand_model(input logic [31:0] raw, output logic [31:0] exp_instr,
                              output logic exp_comp, output logic exp_ill);
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [11:0] imm;
    rd        = raw[11:7];
    rs2       = raw[6:2];
    imm       = {{7{raw[12]}}, raw[6:2]};
    exp_comp  = (raw[1:0] != 2'b11);
    exp_ill   = 1'b0;
    exp_instr = raw;
    if (exp_comp) begin
      exp_instr = {16'h0000, raw[15:0]};
      exp_ill   = 1'b1;
      if ((raw[1:0] == 2'b01) && (raw[15:13] == 3'b000)) begin
        // addi rd, rd, imm
        exp_instr = {imm, rd, 3'b000, rd, 7'b0010011};
        exp_ill   = 1'b0;
      end else if ((raw[1:0] == 2'b01) && (raw[15:13] == 3'b010)) begin
        // addi rd, x0, imm
        exp_instr = {imm, 5'd0, 3'b000, rd, 7'b0010011};
        exp_ill   = 1'b0;
      end else if ((raw[1:0] == 2'b10) && (raw[15:12] == 4'b1000) && (rs2 != 5'd0)) begin
        // add rd, x0, rs2
        exp_instr = {7'b0000000, rs2, 5'd0, 3'b000, rd, 7'b0110011};
        exp_ill   = 1'b0;
      end else if ((raw[1:0] == 2'b10) && (raw[15:12] == 4'b1001) && (rs2 != 5'd0)) begin
        // add rd, rd, rs2
        exp_instr = {7'b0000000, rs2, rd, 3'b000, rd, 7'b0110011};
        exp_ill   = 1'b0;
      end
    end
  endtask

  // Compares one handshake with decode against the model stream
  task automatic check_transfer();
    logic [31:0] raw;
    logic [31:0] exp_instr;
    logic        exp_comp;
    logic        exp_ill;
    if (dummy_o) begin
      assert (dummy_en_i) else fail_run("dummy handed to decode while dummies are disabled");
      assert (!last_xfer_dummy) else fail_run("two dummies handed to decode back to back");
      check_value("dummy_instr", if_pkg::DUMMY_INSTR, instr_o);
      // A dummy stands in front of the next real instruction
      check_value("dummy_pc", model_pc, pc_o);
      dummy_count++;
    end else begin
      raw = {mem_half(model_pc + 32'd2), mem_half(model_pc)};
      expand_model(raw, exp_instr, exp_comp, exp_ill);
      if (after_redirect) begin
        check_value("redirect_pc", redirect_pc, pc_o);
        after_redirect = 1'b0;
      end
      check_value("stream_pc", model_pc, pc_o);
      check_value("stream_instr", exp_instr, instr_o);
      check_value("stream_compressed", 32'(exp_comp), 32'(compressed_o));
      check_value("stream_illegal", 32'(exp_ill), 32'(illegal_c_o));
      model_pc = model_pc + (exp_comp ? 32'd2 : 32'd4);
      xfer_count++;
    end
    last_xfer_dummy = dummy_o;
  endtask

  ////////////////////
  // Stimulus and checks
  ////////////////////

  initial begin
    rst_n           = 1'b0;
    pc_set_i        = 1'b0;
    branch_addr_i   = 32'h0;
    halt_i          = 1'b0;
    kill_i          = 1'b0;
    dummy_en_i      = 1'b0;
    id_ready_i      = 1'b0;
    instr_rvalid_i  = 1'b0;
    instr_rdata_i   = 32'h0;
    lcg_state       = SEED;
    model_pc        = 32'h0;
    redirect_pc     = 32'h0;
    after_redirect  = 1'b0;
    last_xfer_dummy = 1'b0;
    req_prev        = 1'b0;
    addr_prev       = 32'h0;
    kill_prev       = 1'b0;
    hold_prev       = 1'b0;
    held_instr      = 32'h0;
    held_pc         = 32'h0;
    held_flags      = 3'b000;
    halt_left       = 0;
    xfer_count      = 0;
    dummy_count     = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    // Still in reset here
    check_value("reset_req", 32'h0, 32'(instr_req_o));
    check_value("reset_valid", 32'h0, 32'(if_valid_o));
    check_value("reset_alert", 32'h0, 32'(alert_o));
    rst_n = 1'b1;
    for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
      // Memory answers the request taken at the last rising edge
      instr_rvalid_i = req_prev;
      instr_rdata_i  = req_prev ? mem_word(addr_prev) : 32'h0;
      id_ready_i = (rand_next() % 32'd100) < 32'd70;
      if (halt_left > 0) begin
        halt_i = 1'b1;
        halt_left--;
      end else if ((rand_next() % 32'd100) < 32'd4) begin
        halt_i    = 1'b1;
        halt_left = int'(rand_next() % 32'd4);
      end else begin
        halt_i = 1'b0;
      end
      redirect = (rand_next() % 32'd1000) < 32'd15;
      kill_i   = redirect;
      pc_set_i = redirect;
      if (redirect) begin
        branch_addr_i = rand_next() & 32'h0000_0ffe;
      end
      dummy_en_i = (cyc >= RUN_CYCLES / 2);
      #1;

      assert (!alert_o) else
        fail_run($sformatf("checker alert raised with cause %0d", alert_cause_o));
      check_value("alert_cause", 32'(if_pkg::ALERT_NONE), 32'(alert_cause_o));
      if (instr_req_o) begin
        check_value("req_align", 32'h0, 32'(instr_addr_o[1:0]));
      end
      // The first request after a redirect goes to the new word address
      if (kill_prev && !kill_i) begin
        check_value("redirect_req", 32'h1, 32'(instr_req_o));
        check_value("redirect_addr", {redirect_pc[31:2], 2'b00}, instr_addr_o);
      end
      if (halt_i && !kill_i) begin
        check_value("halt_valid", 32'h0, 32'(if_valid_o));
      end
      if (kill_prev) begin
        check_value("kill_valid", 32'h0, 32'(if_valid_o));
      end
      // Stalled outputs must not move
      if (hold_prev && if_valid_o) begin
        check_value("hold_instr", held_instr, instr_o);
        check_value("hold_pc", held_pc, pc_o);
        check_value("hold_flags", 32'(held_flags), 32'({compressed_o, illegal_c_o, dummy_o}));
      end
      if (if_valid_o && id_ready_i) begin
        check_transfer();
      end
      // The redirect takes effect after any transfer in the same cycle
      if (redirect) begin
        model_pc       = branch_addr_i;
        redirect_pc    = branch_addr_i;
        after_redirect = 1'b1;
      end

      req_prev   = instr_req_o;
      addr_prev  = instr_addr_o;
      kill_prev  = kill_i;
      hold_prev  = if_valid_o && !id_ready_i && !kill_i && !pc_set_i;
      held_instr = instr_o;
      held_pc    = pc_o;
      held_flags = {compressed_o, illegal_c_o, dummy_o};
      @(negedge clk);
    end
    if ((xfer_count >= MIN_XFERS) && (dummy_count > 0)) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      fail_run($sformatf("too little traffic, %0d transfers and %0d dummies",
                         xfer_count, dummy_count));
    end
  end

  // Watchdog on the total number of clock cycles
  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    fail_run("run did not finish within the cycle limit");
  end

endmodule

// File: if_stage.sv
////////////////////
// Instruction fetch stage
// PC control, IF/ID register, dummy insertion and the fault checker
////////////////////

`timescale 1ns/10ps

module if_stage #(
  parameter int          FIFO_DEPTH = if_pkg::FIFO_DEPTH_DEFAULT,
  parameter logic [15:0] LFSR_SEED  = if_pkg::LFSR_SEED_DEFAULT
) (
  input  logic                 clk,
  input  logic                 rst_n,
  // Controller
  input  logic                 pc_set_i,
  input  if_pkg::addr_t        branch_addr_i,
  input  logic                 halt_i,
  input  logic                 kill_i,
  input  logic                 dummy_en_i,
  // Decode
  input  logic                 id_ready_i,
  // Instruction memory
  output logic                 instr_req_o,
  output if_pkg::addr_t        instr_addr_o,
  input  logic                 instr_rvalid_i,
  input  if_pkg::instr_t       instr_rdata_i,
  // IF/ID pipe
  output logic                 if_valid_o,
  output if_pkg::instr_t       instr_o,
  output if_pkg::addr_t        pc_o,
  output logic                 compressed_o,
  output logic                 illegal_c_o,
  output logic                 dummy_o,
  // Fault signalling
  output logic                 alert_o,
  output if_pkg::alert_cause_e alert_cause_o
);

  logic           fetch_valid;
  if_pkg::half_t  fetch_lo;
  if_pkg::half_t  fetch_hi;
  logic           fetch_hi_valid;
  if_pkg::addr_t  fetch_pc;
  logic           pop_half;
  logic           pop_word;
  if_pkg::instr_t dec_instr;
  logic           dec_compressed;
  logic           dec_illegal;
  logic           dummy_req;
  logic           dummy_take;
  logic           load_en;
  logic           instr_load;
  logic           first_parcel;

  // IF/ID register
  logic           valid_q;
  if_pkg::instr_t instr_q;
  if_pkg::addr_t  pc_q;
  logic           compressed_q;
  logic           illegal_q;
  logic           dummy_q;
  // Set when the last entry handed to decode was a dummy
  logic           last_dummy_q;

  if_prefetcher #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) prefetcher0 (
    .clk             (clk),
    .rst_n           (rst_n),
    .start_i         (pc_set_i),
    .start_addr_i    (branch_addr_i),
    .flush_i         (kill_i),
    .pop_half_i      (pop_half),
    .pop_word_i      (pop_word),
    .instr_req_o     (instr_req_o),
    .instr_addr_o    (instr_addr_o),
    .instr_rvalid_i  (instr_rvalid_i),
    .instr_rdata_i   (instr_rdata_i),
    .fetch_valid_o   (fetch_valid),
    .fetch_lo_o      (fetch_lo),
    .fetch_hi_o      (fetch_hi),
    .fetch_hi_valid_o(fetch_hi_valid),
    .fetch_pc_o      (fetch_pc)
  );

  // The upper parcel is only meaningful for a 32-bit instruction
  if_compressed_decoder decoder0 (
    .instr_i     ({fetch_hi, fetch_lo}),
    .instr_o     (dec_instr),
    .compressed_o(dec_compressed),
    .illegal_c_o (dec_illegal)
  );

  if_dummy_gen #(
    .LFSR_SEED(LFSR_SEED)
  ) dummy_gen0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .enable_i   (dummy_en_i),
    .take_i     (dummy_take),
    .dummy_req_o(dummy_req)
  );

  ////////////////////
  // Load control
  ////////////////////

  // Halt hides the register from decode without touching its contents
  assign if_valid_o = valid_q && !halt_i;

  // Register is free when empty or when decode takes it this cycle
  assign load_en = (!valid_q || id_ready_i) && !halt_i && !kill_i && !pc_set_i;

  // A dummy never reaches decode right behind another dummy
  assign dummy_take = load_en && dummy_req && !(valid_q ? dummy_q : last_dummy_q);

  // A 32-bit instruction waits until both of its parcels are present
  assign instr_load = load_en && !dummy_take && fetch_valid &&
                      (dec_compressed || fetch_hi_valid);
  assign pop_half   = instr_load && dec_compressed;
  assign pop_word   = instr_load && !dec_compressed;

  // The prefetcher still points at the instruction a held dummy stands in for
  assign first_parcel = (fetch_pc == pc_q);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q      <= 1'b0;
      last_dummy_q <= 1'b0;
    end else begin
      if (kill_i || pc_set_i) begin
        valid_q <= 1'b0;
      end else if (dummy_take || instr_load) begin
        valid_q <= 1'b1;
      end else if (if_valid_o && id_ready_i) begin
        valid_q <= 1'b0;
      end
      if (if_valid_o && id_ready_i) begin
        last_dummy_q <= dummy_q;
      end
    end
  end

  // Payload follows the valid bit and holds while decode stalls
  always_ff @(posedge clk) begin
    if (dummy_take) begin
      instr_q      <= if_pkg::DUMMY_INSTR;
      pc_q         <= fetch_pc;
      compressed_q <= 1'b0;
      illegal_q    <= 1'b0;
      dummy_q      <= 1'b1;
    end else if (instr_load) begin
      instr_q      <= dec_instr;
      pc_q         <= fetch_pc;
      compressed_q <= dec_compressed;
      illegal_q    <= dec_illegal;
      dummy_q      <= 1'b0;
    end
  end

  assign instr_o      = instr_q;
  assign pc_o         = pc_q;
  assign compressed_o = compressed_q;
  assign illegal_c_o  = illegal_q;
  assign dummy_o      = dummy_q;

  ////////////////////
  // Fault checker
  ////////////////////

  if_stage_checker checker0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .halt_i        (halt_i),
    .kill_i        (kill_i),
    .if_valid_i    (if_valid_o),
    .id_ready_i    (id_ready_i),
    .dummy_i       (dummy_q),
    .instr_req_i   (instr_req_o),
    .instr_addr_i  (instr_addr_o),
    .first_parcel_i(first_parcel),
    .alert_o       (alert_o),
    .alert_cause_o (alert_cause_o)
  );

endmodule

// File: if_stage_checker.sv
////////////////////
// Fetch stage run-time checker
// Watches stage invariants and raises a sticky alert with its first cause
////////////////////

`timescale 1ns/10ps

module if_stage_checker (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 halt_i,
  input  logic                 kill_i,
  input  logic                 if_valid_i,
  input  logic                 id_ready_i,
  input  logic                 dummy_i,
  input  logic                 instr_req_i,
  input  if_pkg::addr_t        instr_addr_i,
  input  logic                 first_parcel_i,
  output logic                 alert_o,
  output if_pkg::alert_cause_e alert_cause_o
);

  logic                 kill_q;
  // Set while the last instruction handed to decode was a dummy
  logic                 last_dummy_q;
  logic                 xfer;
  logic                 violation;
  if_pkg::alert_cause_e cause;
  logic                 alert_q;
  if_pkg::alert_cause_e cause_q;

  assign xfer = if_valid_i && id_ready_i;

  ////////////////////
  // Invariants
  ////////////////////

  always_comb begin
    violation = 1'b1;
    cause     = if_pkg::ALERT_NONE;
    if (halt_i && !kill_i && if_valid_i) begin
      cause = if_pkg::ALERT_HALT_VALID;
    end else if (kill_q && if_valid_i) begin
      // The output register must be empty one cycle after a kill
      cause = if_pkg::ALERT_KILL_VALID;
    end else if (instr_req_i && (instr_addr_i[1:0] != 2'b00)) begin
      cause = if_pkg::ALERT_MISALIGNED;
    end else if (xfer && dummy_i && last_dummy_q) begin
      cause = if_pkg::ALERT_DUMMY_B2B;
    end else if (if_valid_i && dummy_i && !first_parcel_i) begin
      // A dummy must sit on the boundary of the next real instruction
      cause = if_pkg::ALERT_DUMMY_MID;
    end else begin
      violation = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      kill_q       <= 1'b0;
      last_dummy_q <= 1'b0;
      alert_q      <= 1'b0;
      cause_q      <= if_pkg::ALERT_NONE;
    end else begin
      kill_q <= kill_i;
      if (xfer) begin
        last_dummy_q <= dummy_i;
      end
      // Only the first fault is recorded, later ones leave it alone
      if (violation && !alert_q) begin
        alert_q <= 1'b1;
        cause_q <= cause;
      end
    end
  end

  assign alert_o       = alert_q;
  assign alert_cause_o = cause_q;

endmodule

// File: if_dummy_gen.sv
////////////////////
// Dummy instruction scheduler
////////////////////

`timescale 1ns/10ps

module if_dummy_gen #(
  parameter logic [15:0] LFSR_SEED = if_pkg::LFSR_SEED_DEFAULT
) (
  input  logic clk,
  input  logic rst_n,
  input  logic enable_i,
  input  logic take_i,
  output logic dummy_req_o
);

  // Taps for x^16 + x^14 + x^13 + x^11 + 1 in right-shift Galois form
  localparam logic [15:0] LFSR_TAPS = 16'hB400;

  logic [15:0] lfsr_q;
  logic [15:0] lfsr_next;
  // Counts from 1 to 16, so a five bit counter is enough
  logic [4:0]  count_q;

  assign lfsr_next = {1'b0, lfsr_q[15:1]} ^ (lfsr_q[0] ? LFSR_TAPS : 16'h0000);

  // Request stays up until the stage can place the dummy
  assign dummy_req_o = enable_i && (count_q == 5'd0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lfsr_q  <= LFSR_SEED;
      count_q <= {1'b0, LFSR_SEED[3:0]} + 5'd1;
    end else begin
      if (take_i) begin
        // A fresh gap of at least one slot is drawn after every dummy
        lfsr_q  <= lfsr_next;
        count_q <= {1'b0, lfsr_q[3:0]} + 5'd1;
      end else if (enable_i && (count_q != 5'd0)) begin
        count_q <= count_q - 5'd1;
      end
    end
  end

endmodule

// File: if_compressed_decoder.sv
////////////////////
// Compressed instruction expander
// Turns C.ADDI, C.LI, C.MV and C.ADD into their 32-bit forms
////////////////////

`timescale 1ns/10ps

module if_compressed_decoder (
  input  if_pkg::instr_t instr_i,
  output if_pkg::instr_t instr_o,
  output logic           compressed_o,
  output logic           illegal_c_o
);

  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  logic [4:0]  rd;
  logic [4:0]  rs2;
  logic [11:0] imm;
  logic [2:0]  funct3;

  // Field positions shared by the supported CI and CR formats
  assign rd     = instr_i[11:7];
  assign rs2    = instr_i[6:2];
  assign funct3 = instr_i[15:13];
  // Six-bit immediate of the CI format, sign extended to twelve bits
  assign imm    = {{7{instr_i[12]}}, instr_i[6:2]};

  // Anything other than 11 in the low bits is a 16-bit parcel
  assign compressed_o = (instr_i[1:0] != 2'b11);

  always_comb begin
    // Unsupported parcels reach decode zero extended and flagged
    instr_o     = {16'h0000, instr_i[15:0]};
    illegal_c_o = 1'b0;
    if (!compressed_o) begin
      // A full-width instruction goes through untouched
      instr_o = instr_i;
    end else begin
      illegal_c_o = 1'b1;
      case (instr_i[1:0])
        2'b01: begin
          if (funct3 == 3'b000) begin
            // C.ADDI becomes addi rd, rd, imm
            instr_o     = {imm, rd, 3'b000, rd, OPC_OP_IMM};
            illegal_c_o = 1'b0;
          end else if (funct3 == 3'b010) begin
            // C.LI becomes addi rd, x0, imm
            instr_o     = {imm, 5'd0, 3'b000, rd, OPC_OP_IMM};
            illegal_c_o = 1'b0;
          end
        end
        2'b10: begin
          // With rs2 zero these encodings are C.JR, C.JALR and C.EBREAK
          if ((funct3 == 3'b100) && (rs2 != 5'd0)) begin
            if (instr_i[12]) begin
              // C.ADD becomes add rd, rd, rs2
              instr_o = {7'b0000000, rs2, rd, 3'b000, rd, OPC_OP};
            end else begin
              // C.MV becomes add rd, x0, rs2
              instr_o = {7'b0000000, rs2, 5'd0, 3'b000, rd, OPC_OP};
            end
            illegal_c_o = 1'b0;
          end
        end
        default: begin
          // Quadrant zero holds no supported instruction
          illegal_c_o = 1'b1;
        end
      endcase
    end
  end

endmodule

// File: if_prefetcher.sv
////////////////////
// Instruction prefetcher
// Fetches aligned words into a FIFO and presents them as a halfword stream
////////////////////

`timescale 1ns/10ps

module if_prefetcher #(
  parameter int FIFO_DEPTH = if_pkg::FIFO_DEPTH_DEFAULT
) (
  input  logic           clk,
  input  logic           rst_n,
  // Redirect and flush from the stage
  input  logic           start_i,
  input  if_pkg::addr_t  start_addr_i,
  input  logic           flush_i,
  // Parcel consumption
  input  logic           pop_half_i,
  input  logic           pop_word_i,
  // Memory side
  output logic           instr_req_o,
  output if_pkg::addr_t  instr_addr_o,
  input  logic           instr_rvalid_i,
  input  if_pkg::instr_t instr_rdata_i,
  // Halfword stream
  output logic           fetch_valid_o,
  output if_pkg::half_t  fetch_lo_o,
  output if_pkg::half_t  fetch_hi_o,
  output logic           fetch_hi_valid_o,
  output if_pkg::addr_t  fetch_pc_o
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  if_pkg::instr_t fifo_q [FIFO_DEPTH];
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [CNT_W-1:0] count_q;
  // All requests in flight, including those that will be dropped
  logic [CNT_W-1:0] outstanding_q;
  // Requests in flight that belong to a stream before the last flush
  logic [CNT_W-1:0] discard_q;
  logic [CNT_W:0]   occupancy;
  logic             running_q;
  // High during reset so that fetching from address zero begins one cycle after it
  logic             boot_q;
  if_pkg::addr_t    fetch_addr_q;
  if_pkg::addr_t    fetch_pc_q;
  logic             clear;
  logic             push;
  logic             pop_entry;
  logic             offset;
  if_pkg::instr_t   head_word;
  if_pkg::instr_t   next_word;

  // A redirect also empties the FIFO and drops what is still in flight
  assign clear  = start_i | flush_i;
  assign offset = fetch_pc_q[1];

  // Space is counted for live requests only since dropped ones never enter the FIFO
  assign occupancy = {1'b0, count_q} + {1'b0, outstanding_q - discard_q};

  // No request goes out in the redirect cycle itself
  assign instr_req_o  = running_q && !clear && (occupancy < (CNT_W+1)'(FIFO_DEPTH));
  assign instr_addr_o = fetch_addr_q;

  assign push = instr_rvalid_i && (discard_q == '0) && !clear;

  // The head word leaves once its upper parcel has been consumed
  assign pop_entry = pop_word_i | (pop_half_i & offset);

  ////////////////////
  // Halfword aligner
  ////////////////////

  assign head_word = fifo_q[rd_ptr_q];
  assign next_word = fifo_q[rd_ptr_q + PTR_W'(1)];

  assign fetch_valid_o    = (count_q != '0);
  assign fetch_lo_o       = offset ? head_word[31:16] : head_word[15:0];
  // With an upper-half start the second parcel comes from the next word
  assign fetch_hi_o       = offset ? next_word[15:0] : head_word[31:16];
  assign fetch_hi_valid_o = offset ? (count_q >= CNT_W'(2)) : (count_q != '0);
  assign fetch_pc_o       = fetch_pc_q;

  // Word storage
  always_ff @(posedge clk) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= instr_rdata_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr_q      <= '0;
      wr_ptr_q      <= '0;
      count_q       <= '0;
      outstanding_q <= '0;
      discard_q     <= '0;
      running_q     <= 1'b0;
      boot_q        <= 1'b1;
      fetch_addr_q  <= '0;
      fetch_pc_q    <= '0;
    end else begin
      boot_q <= 1'b0;
      // Every request is answered by the memory so this count tracks the bus exactly
      outstanding_q <= outstanding_q + CNT_W'(instr_req_o) - CNT_W'(instr_rvalid_i);
      if (clear) begin
        rd_ptr_q  <= '0;
        wr_ptr_q  <= '0;
        count_q   <= '0;
        // Everything still in flight after this edge is stale
        discard_q <= outstanding_q - CNT_W'(instr_rvalid_i);
        // A kill on its own parks the fetcher until the next redirect
        running_q <= start_i;
        if (start_i) begin
          fetch_addr_q <= {start_addr_i[31:2], 2'b00};
          fetch_pc_q   <= start_addr_i;
        end
      end else begin
        if (boot_q) begin
          running_q <= 1'b1;
        end
        if (instr_rvalid_i && (discard_q != '0)) begin
          discard_q <= discard_q - CNT_W'(1);
        end
        if (instr_req_o) begin
          fetch_addr_q <= fetch_addr_q + 32'd4;
        end
        if (push) begin
          wr_ptr_q <= wr_ptr_q + PTR_W'(1);
        end
        if (pop_entry) begin
          rd_ptr_q <= rd_ptr_q + PTR_W'(1);
        end
        count_q <= count_q + CNT_W'(push) - CNT_W'(pop_entry);
        if (pop_half_i) begin
          fetch_pc_q <= fetch_pc_q + 32'd2;
        end else if (pop_word_i) begin
          fetch_pc_q <= fetch_pc_q + 32'd4;
        end
      end
    end
  end

endmodule

// File: if_pkg.sv
////////////////////
// Instruction fetch package
// Shared types, the dummy encoding and the checker's alert causes
////////////////////

package if_pkg;

  // Instruction word as fetched from memory or handed to decode
  typedef logic [31:0] instr_t;

  // Byte address on the fetch bus and in the PC path
  typedef logic [31:0] addr_t;

  // One 16-bit parcel of the halfword stream
  typedef logic [15:0] half_t;

  ////////////////////
  // Dummy instruction
  ////////////////////

  // The dummy is an ADD whose result lands in x0, so it has no
  // architectural effect. It still exercises the ALU with two fixed
  // source registers, x10 and x11
  localparam instr_t DUMMY_INSTR = {7'b0000000, 5'd11, 5'd10, 3'b000, 5'd0, 7'b0110011};

  ////////////////////
  // Checker causes
  ////////////////////

  // Only the first cause seen is kept
  typedef enum logic [2:0] {
    ALERT_NONE       = 3'd0,
    // Valid output while halted and not killed
    ALERT_HALT_VALID = 3'd1,
    // Valid output in the cycle after a kill
    ALERT_KILL_VALID = 3'd2,
    // Fetch request address not word aligned
    ALERT_MISALIGNED = 3'd3,
    // Two dummies handed to decode in a row
    ALERT_DUMMY_B2B  = 3'd4,
    // Dummy emitted inside a partly consumed instruction
    ALERT_DUMMY_MID  = 3'd5
  } alert_cause_e;

  ////////////////////
  // Parameter defaults
  ////////////////////

  // Word FIFO depth, must be a power of two of 2 or more
  localparam int FIFO_DEPTH_DEFAULT = 4;

  // Starting state of the 16-bit dummy LFSR, must not be zero
  localparam logic [15:0] LFSR_SEED_DEFAULT = 16'hACE1;

endpackage
